/* wtree_mult.f */
logic/booth_pp_pkg.sv
logic/wtree_pkg.sv
logic/pp_capture.sv
logic/csa_row.sv
logic/reduce_tree.sv
logic/final_stage.sv
logic/wtree_mult_top.sv
tb/tb_model_pkg.sv
tb/tb_wtree_mult.sv

/* tb/tb_wtree_mult.sv */
`timescale 1ns/1ps

module tb_wtree_mult;

  localparam logic [wtree_pkg::PIPE_BITS-1:0] tb_pipe_mask = '1;
  localparam int lat = tb_model_pkg::model_latency(tb_pipe_mask);
  // single rows, late rows, random bundles and extremes, plus zero bundles around them
  localparam int total_vectors = 36 + 8 + 400 + 4 + 2 * lat;
  localparam int timeout_ns = (8 + total_vectors + lat + 20) * 10;

  logic clk;
  logic rstn;
  booth_pp_pkg::pp_bundle_t pp;
  booth_pp_pkg::product_t final_p;

  integer seed;
  int error_count;
  int check_count;
  int push_count;
  int pop_count;
  booth_pp_pkg::product_t exp_q[$];
  string name_q[$];

  wtree_mult_top #(
    .pipe_mask (tb_pipe_mask)
  ) dut (
    .clk     (clk),
    .rstn    (rstn),
    .pp      (pp),
    .final_p (final_p)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input string name, input booth_pp_pkg::product_t expected,
                             input booth_pp_pkg::product_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // the bundle is sampled at the next edge and its product is queued for the monitor
  task automatic apply_bundle(input booth_pp_pkg::pp_bundle_t b, input string name);
    @(posedge clk);
    pp <= b;
    exp_q.push_back(tb_model_pkg::model_product(b));
    name_q.push_back(name);
    push_count++;
  endtask

  // outputs are stable at the falling edge and lat bundles stay in flight
  initial begin
    booth_pp_pkg::product_t expected;
    string name;
    @(posedge clk);
    forever begin
      @(negedge clk);
      if (!rstn) begin
        check_value("reset", '0, final_p);
      end else if (exp_q.size() > lat) begin
        expected = exp_q.pop_front();
        name = name_q.pop_front();
        pop_count++;
        check_value(name, expected, final_p);
      end else if (pop_count == 0) begin
        check_value("post_reset", '0, final_p);
      end
    end
  end

  initial begin
    booth_pp_pkg::pp_bundle_t b;
    booth_pp_pkg::pp_row_t v;
    seed = 70222;
    error_count = 0;
    check_count = 0;
    push_count = 0;
    pop_count = 0;
    rstn = 1'b0;
    pp = '0;
    repeat (8) @(posedge clk);
    rstn <= 1'b1;
    for (int i = 0; i < lat; i++) begin
      apply_bundle('0, "post_reset");
    end
    // one nonzero row at a time, positive, negative, minus one and one
    for (int k = 0; k < booth_pp_pkg::PP_ROWS; k++) begin
      for (int j = 0; j < 4; j++) begin
        v = booth_pp_pkg::pp_row_t'($random(seed));
        case (j)
          0: v[booth_pp_pkg::PP_W-1] = 1'b0;
          1: v[booth_pp_pkg::PP_W-1] = 1'b1;
          2: v = '1;
          default: v = 20'h00001;
        endcase
        b = '0;
        b.rows[k] = v;
        apply_bundle(b, $sformatf("single_row_%0d", k + 1));
      end
    end
    for (int i = 0; i < 8; i++) begin
      b = '0;
      b.late = booth_pp_pkg::late_row_t'($random(seed));
      apply_bundle(b, "late_row");
    end
    for (int i = 0; i < 400; i++) begin
      b.late = booth_pp_pkg::late_row_t'($random(seed));
      for (int k = 0; k < booth_pp_pkg::PP_ROWS; k++) begin
        b.rows[k] = booth_pp_pkg::pp_row_t'($random(seed));
      end
      apply_bundle(b, "random");
    end
    b = '0;
    for (int k = 0; k < booth_pp_pkg::PP_ROWS; k++) begin
      b.rows[k] = '1;
    end
    apply_bundle(b, "rows_all_ones");
    b = '0;
    for (int k = 0; k < booth_pp_pkg::PP_ROWS; k++) begin
      b.rows[k] = 20'h80000;
    end
    apply_bundle(b, "rows_most_negative");
    b = '0;
    b.late = '1;
    apply_bundle(b, "late_all_ones");
    b = '1;
    apply_bundle(b, "all_ones");
    for (int i = 0; i < lat; i++) begin
      apply_bundle('0, "flush");
    end
    wait (pop_count >= push_count - lat);
    $display("checks %0d errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("timeout, the products did not all arrive within %0d ns", timeout_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* tb/tb_model_pkg.sv */
package tb_model_pkg;

  // the nine regular rows are two's complement values, row k weighs 2^(2(k-1))
  // the late row is unsigned and weighs 2^18
  // a 64-bit accumulator holds the exact sum, whose low 36 bits are the product
  function automatic booth_pp_pkg::product_t model_product(
    input booth_pp_pkg::pp_bundle_t b
  );
    longint acc;
    longint row_val;
    longint late_val;
    acc = 0;
    for (int k = 0; k < booth_pp_pkg::PP_ROWS; k++) begin
      row_val = $signed(b.rows[k]);
      acc = acc + row_val * (longint'(1) << (booth_pp_pkg::ROW_SHIFT * k));
    end
    late_val = b.late;
    acc = acc + late_val * (longint'(1) << booth_pp_pkg::LATE_WEIGHT);
    return acc[booth_pp_pkg::PROD_W-1:0];
  endfunction

  // every set bit of the mask adds one register rank on the path to final_p
  function automatic int model_latency(
    input logic [wtree_pkg::PIPE_BITS-1:0] mask
  );
    int n;
    n = 0;
    for (int i = 0; i < wtree_pkg::PIPE_BITS; i++) begin
      if (mask[i]) begin
        n++;
      end
    end
    return n;
  endfunction

endpackage

/* logic/wtree_mult_top.sv */
`timescale 1ns/1ps

module wtree_mult_top #(
  parameter logic [wtree_pkg::PIPE_BITS-1:0] pipe_mask = '1
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  booth_pp_pkg::pp_bundle_t pp,
  output booth_pp_pkg::product_t   final_p
);

  wtree_pkg::pp_triple_t [wtree_pkg::CSA_GROUPS-1:0] triples;
  booth_pp_pkg::late_row_t late_row;
  wire wtree_pkg::csa24_t [wtree_pkg::CSA_GROUPS-1:0] pairs;
  wtree_pkg::csa36_t tree_pair;

  pp_capture #(
    .pipe_mask (pipe_mask)
  ) u_pp_capture (
    .clk      (clk),
    .rstn     (rstn),
    .pp       (pp),
    .triples  (triples),
    .late_row (late_row)
  );

  // group g reduces rows 3g+1 to 3g+3 at base weight 6g
  for (genvar g = 0; g < wtree_pkg::CSA_GROUPS; g++) begin : g_csa
    csa_row #(
      .pipe_mask (pipe_mask)
    ) u_csa_row (
      .clk  (clk),
      .rstn (rstn),
      .rows (triples[g]),
      .pair (pairs[g])
    );
  end

  reduce_tree #(
    .pipe_mask (pipe_mask)
  ) u_reduce_tree (
    .clk   (clk),
    .rstn  (rstn),
    .pairs (pairs),
    .pair  (tree_pair)
  );

  final_stage #(
    .pipe_mask (pipe_mask)
  ) u_final_stage (
    .clk      (clk),
    .rstn     (rstn),
    .pair     (tree_pair),
    .late_row (late_row),
    .final_p  (final_p)
  );

endmodule

/* logic/final_stage.sv */
`timescale 1ns/1ps

module final_stage #(
  parameter logic [wtree_pkg::PIPE_BITS-1:0] pipe_mask = '1
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  wtree_pkg::csa36_t       pair,
  input  booth_pp_pkg::late_row_t late_row,
  output booth_pp_pkg::product_t  final_p
);

  localparam int TW = booth_pp_pkg::PROD_W;
  localparam int LW = booth_pp_pkg::LATE_W;
  localparam int LWT = booth_pp_pkg::LATE_WEIGHT;

  wire [LW-1:0] late_dly [0:4];
  logic [TW-1:0] t5_x;
  logic [TW-1:0] t5_y;
  logic [TW-1:0] t5_z;
  wtree_pkg::csa36_t stg5_d;
  wtree_pkg::csa36_t stg5;
  booth_pp_pkg::product_t sum_d;

  // one delay per register rank that the tree uses between stage 1 and stage 4
  assign late_dly[0] = late_row;

  for (genvar i = 0; i < 4; i++) begin : g_late
    if (pipe_mask[wtree_pkg::PIPE_STG1 + i]) begin : g_reg
      booth_pp_pkg::late_row_t late_r;

      always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
          late_r <= '0;
        end else begin
          late_r <= late_dly[i];
        end
      end

      assign late_dly[i+1] = late_r;
    end else begin : g_thru
      assign late_dly[i+1] = late_dly[i];
    end
  end

  // late row is zero-extended and joins at weight 18
  assign t5_x = pair.sum;
  assign t5_y = {pair.carry[TW-2:0], 1'b0};
  assign t5_z = {{(TW-LW-LWT){1'b0}}, late_dly[4], {LWT{1'b0}}};

  assign stg5_d.sum   = t5_x ^ t5_y ^ t5_z;
  assign stg5_d.carry = (t5_x & t5_y) | (t5_x & t5_z) | (t5_y & t5_z);

  generate
    if (pipe_mask[wtree_pkg::PIPE_STG5]) begin : g_stg5_reg
      always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
          stg5 <= '0;
        end else begin
          stg5 <= stg5_d;
        end
      end
    end else begin : g_stg5_comb
      always_comb begin
        stg5 = stg5_d;
      end
    end
  endgenerate

  assign sum_d = stg5.sum + {stg5.carry[TW-2:0], 1'b0};

  generate
    if (pipe_mask[wtree_pkg::PIPE_OUT]) begin : g_out_reg
      always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
          final_p <= '0;
        end else begin
          final_p <= sum_d;
        end
      end
    end else begin : g_out_comb
      always_comb begin
        final_p = sum_d;
      end
    end
  endgenerate

  // catches an X from any rank of the whole tree, including the late-row delay line
  a_product_known: assert property (
    @(posedge clk) disable iff (!rstn)
    !$isunknown(final_p)
  ) else $error("product holds unknown bits after reset");

endmodule

/* logic/reduce_tree.sv */
`timescale 1ns/1ps

module reduce_tree #(
  parameter logic [wtree_pkg::PIPE_BITS-1:0] pipe_mask = '1
) (
  input  logic                                          clk,
  input  logic                                          rstn,
  input  wtree_pkg::csa24_t [wtree_pkg::CSA_GROUPS-1:0] pairs,
  output wtree_pkg::csa36_t                             pair
);

  localparam int GW = wtree_pkg::GROUP_W;
  localparam int TW = booth_pp_pkg::PROD_W;

  logic [29:0] a2_x;
  logic [29:0] a2_y;
  logic [29:0] a2_z;
  logic [28:0] b2_x;
  logic [28:0] b2_y;
  logic [28:0] b2_z;
  logic [TW-1:0] t3_x;
  logic [TW-1:0] t3_y;
  logic [TW-1:0] t3_z;
  logic [TW-1:0] t4_x;
  logic [TW-1:0] t4_y;
  logic [TW-1:0] t4_z;

  wtree_pkg::csa30_t stg2_a_d;
  wtree_pkg::csa30_t stg2_a;
  wtree_pkg::csa29_t stg2_b_d;
  wtree_pkg::csa29_t stg2_b;
  wtree_pkg::csa36_t stg3_d;
  wtree_pkg::csa36_t stg3;
  wtree_pkg::left_carry_t left_carry;
  wtree_pkg::csa36_t stg4_d;
  logic [TW-1:0] stg2_value;
  logic [TW-1:0] stg4_value;

  // stage 2a works at weight 0 with group 1 and the sum of group 2 at offset 6
  assign a2_x = {{(30-GW){pairs[0].sum[GW-1]}}, pairs[0].sum};
  assign a2_y = {{(29-GW){pairs[0].carry[GW-1]}}, pairs[0].carry, 1'b0};
  assign a2_z = {pairs[1].sum, 6'b0};

  assign stg2_a_d.sum   = a2_x ^ a2_y ^ a2_z;
  assign stg2_a_d.carry = (a2_x & a2_y) | (a2_x & a2_z) | (a2_y & a2_z);

  // stage 2b is anchored at weight 7, where the carry of group 2 starts
  // its bits above weight 35 are dropped, so the top carry of group 3 never enters
  assign b2_x = {{(29-GW){pairs[1].carry[GW-1]}}, pairs[1].carry};
  assign b2_y = {pairs[2].sum, 5'b0};
  assign b2_z = {pairs[2].carry[GW-2:0], 6'b0};

  assign stg2_b_d.sum   = b2_x ^ b2_y ^ b2_z;
  assign stg2_b_d.carry = (b2_x & b2_y) | (b2_x & b2_z) | (b2_y & b2_z);

  generate
    if (pipe_mask[wtree_pkg::PIPE_STG2]) begin : g_stg2_reg
      always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
          stg2_a <= '0;
          stg2_b <= '0;
        end else begin
          stg2_a <= stg2_a_d;
          stg2_b <= stg2_b_d;
        end
      end
    end else begin : g_stg2_comb
      always_comb begin
        stg2_a = stg2_a_d;
        stg2_b = stg2_b_d;
      end
    end
  endgenerate

  assign t3_x = {{(TW-30){stg2_a.sum[29]}}, stg2_a.sum};
  assign t3_y = {{(TW-31){stg2_a.carry[29]}}, stg2_a.carry, 1'b0};
  assign t3_z = {stg2_b.sum, 7'b0};

  assign stg3_d.sum   = t3_x ^ t3_y ^ t3_z;
  assign stg3_d.carry = (t3_x & t3_y) | (t3_x & t3_z) | (t3_y & t3_z);

  // the carry of stage 2b skips stage 3 and rides along in its register rank
  generate
    if (pipe_mask[wtree_pkg::PIPE_STG3]) begin : g_stg3_reg
      always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
          stg3       <= '0;
          left_carry <= '0;
        end else begin
          stg3       <= stg3_d;
          left_carry <= stg2_b.carry[27:0];
        end
      end
    end else begin : g_stg3_comb
      always_comb begin
        stg3       = stg3_d;
        left_carry = stg2_b.carry[27:0];
      end
    end
  endgenerate

  assign t4_x = stg3.sum;
  assign t4_y = {stg3.carry[TW-2:0], 1'b0};
  assign t4_z = {left_carry, 8'b0};

  assign stg4_d.sum   = t4_x ^ t4_y ^ t4_z;
  assign stg4_d.carry = (t4_x & t4_y) | (t4_x & t4_z) | (t4_y & t4_z);

  generate
    if (pipe_mask[wtree_pkg::PIPE_STG4]) begin : g_stg4_reg
      always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
          pair <= '0;
        end else begin
          pair <= stg4_d;
        end
      end
    end else begin : g_stg4_comb
      always_comb begin
        pair = stg4_d;
      end
    end
  endgenerate

  // stage 3 result and the skipped carry must meet in the same cycle to keep the sum
  assign stg2_value = t3_x + t3_y + t3_z + {stg2_b.carry[27:0], 8'b0};
  assign stg4_value = stg4_d.sum + {stg4_d.carry[TW-2:0], 1'b0};

  generate
    if (pipe_mask[wtree_pkg::PIPE_STG3]) begin : g_conserve_reg
      a_stg4_conserve: assert property (
        @(posedge clk) disable iff (!rstn)
        $past(rstn) |-> (stg4_value == $past(stg2_value))
      ) else $error("stage 4 changes the carry-save value");
    end else begin : g_conserve_comb
      a_stg4_conserve: assert property (
        @(posedge clk) disable iff (!rstn)
        stg4_value == stg2_value
      ) else $error("stage 4 changes the carry-save value");
    end
  endgenerate

endmodule

/* logic/csa_row.sv */
`timescale 1ns/1ps

module csa_row #(
  parameter logic [wtree_pkg::PIPE_BITS-1:0] pipe_mask = '1
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  wtree_pkg::pp_triple_t rows,
  output wtree_pkg::csa24_t     pair
);

  localparam int W  = wtree_pkg::GROUP_W;
  localparam int PW = booth_pp_pkg::PP_W;
  localparam int SH = booth_pp_pkg::ROW_SHIFT;

  logic [W-1:0] op_lo;
  logic [W-1:0] op_mid;
  logic [W-1:0] op_hi;
  wtree_pkg::csa24_t pair_d;

  // each row keeps its own sign bit up to bit 23
  assign op_lo  = {{(W-PW){rows.lo[PW-1]}}, rows.lo};
  assign op_mid = {{(W-PW-SH){rows.mid[PW-1]}}, rows.mid, {SH{1'b0}}};
  assign op_hi  = {rows.hi, {(2*SH){1'b0}}};

  // a full adder per column
  // where an operand is zero the column degenerates to a half adder or a pass-through
  assign pair_d.sum   = op_lo ^ op_mid ^ op_hi;
  assign pair_d.carry = (op_lo & op_mid) | (op_lo & op_hi) | (op_mid & op_hi);

  generate
    if (pipe_mask[wtree_pkg::PIPE_STG1]) begin : g_stg1_reg
      always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
          pair <= '0;
        end else begin
          pair <= pair_d;
        end
      end
    end else begin : g_stg1_comb
      always_comb begin
        pair = pair_d;
      end
    end
  endgenerate

  // the pair must hold the three signed rows at offsets 0, 2 and 4
  a_csa_value: assert property (
    @(posedge clk) disable iff (!rstn)
    (pair_d.sum + {pair_d.carry[W-2:0], 1'b0})
      == W'($signed(rows.lo) + ($signed(rows.mid) <<< SH)
            + ($signed(rows.hi) <<< (2 * SH)))
  ) else $error("first-stage pair does not match the offset row sum");

endmodule

/* logic/pp_capture.sv */
`timescale 1ns/1ps

module pp_capture #(
  parameter logic [wtree_pkg::PIPE_BITS-1:0] pipe_mask = '1
) (
  input  logic                                              clk,
  input  logic                                              rstn,
  input  booth_pp_pkg::pp_bundle_t                          pp,
  output wtree_pkg::pp_triple_t [wtree_pkg::CSA_GROUPS-1:0] triples,
  output booth_pp_pkg::late_row_t                           late_row
);

  booth_pp_pkg::pp_bundle_t pp_q;

  generate
    if (pipe_mask[wtree_pkg::PIPE_IN]) begin : g_in_reg
      always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
          pp_q <= '0;
        end else begin
          pp_q <= pp;
        end
      end
    end else begin : g_in_comb
      always_comb begin
        pp_q = pp;
      end
    end
  endgenerate

  // group g collects rows 3g+1 to 3g+3, so each group starts at weight 6g
  always_comb begin
    for (int g = 0; g < wtree_pkg::CSA_GROUPS; g++) begin
      triples[g].lo  = pp_q.rows[3*g];
      triples[g].mid = pp_q.rows[3*g+1];
      triples[g].hi  = pp_q.rows[3*g+2];
    end
  end

  assign late_row = pp_q.late;

  // the late row bypasses stages 1 to 4, so an X here would only show up at the adder
  a_late_row_known: assert property (
    @(posedge clk) disable iff (!rstn)
    !$isunknown(late_row)
  ) else $error("late row carries unknown bits after reset");

endmodule

/* logic/wtree_pkg.sv */
package wtree_pkg;

  localparam int CSA_GROUPS = 3;
  localparam int GROUP_W = 24;

  // one bit per optional register rank in pipe_mask
  localparam int PIPE_BITS = 7;
  localparam int PIPE_IN = 0;
  localparam int PIPE_STG1 = 1;
  localparam int PIPE_STG2 = 2;
  localparam int PIPE_STG3 = 3;
  localparam int PIPE_STG4 = 4;
  localparam int PIPE_STG5 = 5;
  localparam int PIPE_OUT = 6;

  // lo sits at offset 0, mid at offset 2 and hi at offset 4 inside a group
  typedef struct packed {
    booth_pp_pkg::pp_row_t hi;
    booth_pp_pkg::pp_row_t mid;
    booth_pp_pkg::pp_row_t lo;
  } pp_triple_t;

  // in every pair carry[i] weighs 2^(i+1), so the value is sum plus twice carry
  typedef struct packed {
    logic [GROUP_W-1:0] sum;
    logic [GROUP_W-1:0] carry;
  } csa24_t;

  typedef struct packed {
    logic [29:0] sum;
    logic [29:0] carry;
  } csa30_t;

  typedef struct packed {
    logic [28:0] sum;
    logic [28:0] carry;
  } csa29_t;

  typedef struct packed {
    logic [booth_pp_pkg::PROD_W-1:0] sum;
    logic [booth_pp_pkg::PROD_W-1:0] carry;
  } csa36_t;

  typedef logic [27:0] left_carry_t;

endpackage

/* logic/booth_pp_pkg.sv */
package booth_pp_pkg;

  localparam int PP_W = 20;
  localparam int PP_ROWS = 9;
  localparam int ROW_SHIFT = 2;

  // the tenth Booth row only carries the correction term and is never negative
  localparam int LATE_W = 18;
  localparam int LATE_WEIGHT = 18;

  localparam int PROD_W = 36;

  typedef logic [PP_W-1:0] pp_row_t;

  typedef logic [LATE_W-1:0] late_row_t;

  // rows[0] is row one at weight 0 and rows[k] sits at weight ROW_SHIFT*k
  typedef struct packed {
    late_row_t                  late;
    pp_row_t [PP_ROWS-1:0]      rows;
  } pp_bundle_t;

  typedef logic [PROD_W-1:0] product_t;

endpackage
